/* bench/dnaRefModel.svh */
// Walks the pattern token by token against the sequence, anchored at letter 0
function automatic void referenceMatch(
    input  dnaPkg::tokenT  pat [dnaPkg::PatDepth],
    input  dnaPkg::letterT seq [dnaPkg::SeqDepth],
    output int             expFound,
    output int             expError,
    output int             expLength
);
    int                 p;
    int                 s;
    int                 k;
    int                 run;
    int                 members;
    logic               walking;
    dnaPkg::letterMaskT mask;
    dnaPkg::tokenT      tok;
    dnaPkg::tokenT      lit;
    expFound = 0;
    expError = 0;
    expLength = 0;
    p = 0;
    s = 0;
    walking = 1'b1;
    while (walking) begin
        if (p >= dnaPkg::PatDepth) begin
            expError = 1;  // No end token inside the pattern
            walking = 1'b0;
        end else begin
            tok = pat[p];
            if (tok < dnaPkg::TokenSet2) begin
                if (seq[s] == dnaPkg::letterT'(tok)) begin
                    p++;
                    s++;
                end else begin
                    walking = 1'b0;
                end
            end else if (tok == dnaPkg::TokenSet2 || tok == dnaPkg::TokenSet3) begin
                members = (tok == dnaPkg::TokenSet3) ? 3 : 2;
                mask = '0;
                for (k = 1; k <= members && expError == 0; k++) begin
                    if (p + k >= dnaPkg::PatDepth) begin
                        expError = 1;
                    end else if (pat[p + k] >= dnaPkg::TokenSet2 || mask[pat[p + k][1:0]]) begin
                        expError = 1;  // Non-letter or repeated member
                    end else begin
                        mask[pat[p + k][1:0]] = 1'b1;
                    end
                end
                if (expError != 0) begin
                    walking = 1'b0;
                end else if (seq[s] <= dnaPkg::LetterG && mask[seq[s][1:0]]) begin
                    p += members + 1;
                    s++;
                end else begin
                    walking = 1'b0;
                end
            end else if (tok == dnaPkg::TokenOneOrMore || tok == dnaPkg::TokenZeroOrMore) begin
                if (p + 1 >= dnaPkg::PatDepth || pat[p + 1] >= dnaPkg::TokenSet2) begin
                    expError = 1;
                    walking = 1'b0;
                end else begin
                    lit = pat[p + 1];
                    run = 0;
                    // Greedy, never gives letters back
                    while (run < dnaPkg::MaxRun && seq[s] == dnaPkg::letterT'(lit)) begin
                        run++;
                        s++;
                    end
                    if (tok == dnaPkg::TokenOneOrMore && run == 0) begin
                        walking = 1'b0;
                    end else begin
                        p += 2;
                    end
                end
            end else if (tok == dnaPkg::TokenEnd) begin
                expFound = 1;
                expLength = s;
                walking = 1'b0;
            end else begin
                expError = 1;  // Codes 9 to 15
                walking = 1'b0;
            end
        end
    end
endfunction

/* bench/dnaMatcherTb.sv */
`timescale 1ns/100ps

module dnaMatcherTb;

    localparam int DirectedCount = 24;
    localparam int RandomCount = 200;
    localparam int TimeoutCycles = (DirectedCount + RandomCount) * 400;

    logic                        clock;
    logic                        reset_N;
    logic                        patWrite;
    logic [dnaPkg::PatAddrW-1:0] patAddr;
    dnaPkg::tokenT               patData;
    logic                        seqWrite;
    logic [dnaPkg::SeqAddrW-1:0] seqAddr;
    dnaPkg::letterT              seqData;
    logic                        start;
    logic                        busy;
    logic                        done;
    logic                        foundIt;
    logic                        error;
    logic [dnaPkg::SeqAddrW-1:0] matchLength;

    dnaPkg::tokenT  patImage [dnaPkg::PatDepth];
    dnaPkg::letterT seqImage [dnaPkg::SeqDepth];
    integer         seed;
    int             cycleCount = 0;

    dnaMatcher dut (
        .clock(clock),
        .reset_N(reset_N),
        .patWrite(patWrite),
        .patAddr(patAddr),
        .patData(patData),
        .seqWrite(seqWrite),
        .seqAddr(seqAddr),
        .seqData(seqData),
        .start(start),
        .busy(busy),
        .done(done),
        .foundIt(foundIt),
        .error(error),
        .matchLength(matchLength)
    );

    `include "dnaRefModel.svh"

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TimeoutCycles) begin
            $display("Timeout: a search never finished within %0d cycles", TimeoutCycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic dnaPkg::tokenT tokenFor(input byte ch);
        case (ch)
            "A": return dnaPkg::tokenT'(dnaPkg::LetterA);
            "C": return dnaPkg::tokenT'(dnaPkg::LetterC);
            "T": return dnaPkg::tokenT'(dnaPkg::LetterT);
            "G": return dnaPkg::tokenT'(dnaPkg::LetterG);
            "2": return dnaPkg::TokenSet2;
            "3": return dnaPkg::TokenSet3;
            "+": return dnaPkg::TokenOneOrMore;
            "*": return dnaPkg::TokenZeroOrMore;
            "$": return dnaPkg::TokenEnd;
            default: return dnaPkg::tokenT'(9);  // Invalid code
        endcase
    endfunction

    function automatic dnaPkg::letterT letterFor(input byte ch);
        case (ch)
            "A": return dnaPkg::LetterA;
            "C": return dnaPkg::LetterC;
            "T": return dnaPkg::LetterT;
            "G": return dnaPkg::LetterG;
            default: return dnaPkg::LetterOther;
        endcase
    endfunction

    task automatic loadPattern(input string text);
        int i;
        for (i = 0; i < dnaPkg::PatDepth; i++) begin
            if (i < text.len()) begin
                patImage[i] = tokenFor(text[i]);
            end else begin
                patImage[i] = dnaPkg::tokenT'(i[3:0] ^ {3'b000, i[4]});  // Never read
            end
        end
    endtask

    task automatic loadSequence(input string text);
        int i;
        for (i = 0; i < dnaPkg::SeqDepth; i++) begin
            if (i < text.len()) begin
                seqImage[i] = letterFor(text[i]);
            end else if (i == text.len()) begin
                seqImage[i] = dnaPkg::LetterEnd;
            end else begin
                seqImage[i] = dnaPkg::letterT'(i[2:0] ^ i[5:3]);
            end
        end
    endtask

    // Mostly valid tokens and sequences with frequent runs
    task automatic randomImages();
        int i;
        int pick;
        int length;
        for (i = 0; i < dnaPkg::PatDepth; i++) begin
            pick = {$random(seed)} % 100;
            if (pick < 60) begin
                patImage[i] = dnaPkg::tokenT'({$random(seed)} % 4);
            end else if (pick < 66) begin
                patImage[i] = dnaPkg::TokenSet2;
            end else if (pick < 70) begin
                patImage[i] = dnaPkg::TokenSet3;
            end else if (pick < 78) begin
                patImage[i] = dnaPkg::TokenOneOrMore;
            end else if (pick < 86) begin
                patImage[i] = dnaPkg::TokenZeroOrMore;
            end else if (pick < 97) begin
                patImage[i] = dnaPkg::TokenEnd;
            end else begin
                patImage[i] = dnaPkg::tokenT'({$random(seed)} % 16);
            end
        end
        length = {$random(seed)} % dnaPkg::SeqDepth;
        for (i = 0; i < dnaPkg::SeqDepth; i++) begin
            pick = {$random(seed)} % 100;
            if (i > length) begin
                seqImage[i] = dnaPkg::letterT'(i[2:0] ^ i[5:3]);
            end else if (i == length) begin
                seqImage[i] = dnaPkg::LetterEnd;
            end else if (pick < 5) begin
                seqImage[i] = dnaPkg::LetterOther;
            end else if (pick < 50 && i > 0) begin
                seqImage[i] = seqImage[i - 1];
            end else begin
                seqImage[i] = dnaPkg::letterT'({$random(seed)} % 4);
            end
        end
    endtask

    task automatic runSearch(input string label);
        int i;
        int expFound;
        int expError;
        int expLength;
        for (i = 0; i < dnaPkg::SeqDepth; i++) begin
            @(negedge clock);
            patWrite = i < dnaPkg::PatDepth;
            patAddr = dnaPkg::patAddrT'(i);
            patData = patImage[i % dnaPkg::PatDepth];
            seqWrite = 1'b1;
            seqAddr = dnaPkg::seqAddrT'(i);
            seqData = seqImage[i];
        end
        @(negedge clock);
        patWrite = 1'b0;
        seqWrite = 1'b0;
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        checkValue(int'(done), 0, {label, ": done after start"});
        checkValue(int'(foundIt), 0, {label, ": foundIt after start"});
        checkValue(int'(error), 0, {label, ": error after start"});
        checkValue(int'(matchLength), 0, {label, ": matchLength after start"});
        while (!done) begin
            checkValue(int'(busy), 1, {label, ": busy during search"});
            @(negedge clock);
        end
        checkValue(int'(busy), 0, {label, ": busy with done"});
        referenceMatch(patImage, seqImage, expFound, expError, expLength);
        checkValue(int'(foundIt), expFound, {label, ": foundIt"});
        checkValue(int'(error), expError, {label, ": error"});
        checkValue(int'(matchLength), expLength, {label, ": matchLength"});
    endtask

    task automatic searchText(input string patText, input string seqText);
        loadPattern(patText);
        loadSequence(seqText);
        runSearch({patText, " on ", seqText});
    endtask

    initial begin
        int n;
        reset_N = 1'b0;
        start = 1'b0;
        patWrite = 1'b0;
        patAddr = '0;
        patData = '0;
        seqWrite = 1'b0;
        seqAddr = '0;
        seqData = '0;
        seed = 32'h9d6962aa;
        repeat (10) @(negedge clock);
        reset_N = 1'b1;
        @(negedge clock);
        checkValue(int'(busy), 0, "busy after reset");
        checkValue(int'(done), 0, "done after reset");
        checkValue(int'(foundIt | error), 0, "result flags after reset");

        searchText("ACG$", "ACGTT");
        searchText("ACG$", "ATG");
        searchText("AC$", "ANC");       // Other letter matches nothing
        searchText("$", "");
        searchText("2AC$", "C");
        searchText("3ACG$", "G");
        searchText("2AC$", "T");
        searchText("3CTG$", "A");
        searchText("A2CT3ACGG$", "ATCGA");
        searchText("2AA$", "A");        // Duplicate member
        searchText("2A+$", "A");
        searchText("3ACx$", "C");
        searchText("Ax$", "A");
        searchText("AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA", "AAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAAA");
        searchText("+A$", "AAAC");
        searchText("+A$", "C");
        searchText("*AC$", "C");
        searchText("*AC$", "AAC");
        searchText("+A$", "AAAAAAAAAAAAAAAAAAAA");  // Capped at the run limit
        searchText("*AA$", "AAAAAAAAAAAAAAAA");
        searchText("+AA$", "AAAAAAAAAAAAAAA");
        searchText("+2AC$", "A");
        searchText("*T$", "");
        searchText("ACGT$", "AC");      // Sequence ends first

        for (n = 0; n < RandomCount; n++) begin
            randomImages();
            runSearch($sformatf("random search %0d", n));
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the DNA matcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sources.f \
    --top-module dnaMatcherTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi

/* sources.f */
+incdir+bench
verilog/dnaPkg.sv
verilog/symbolStore.sv
verilog/fetchStage.sv
verilog/setCollector.sv
verilog/matchController.sv
verilog/dnaMatcher.sv
bench/dnaMatcherTb.sv

/* verilog/dnaMatcher.sv */
`timescale 1ns/100ps

module dnaMatcher (
    input  logic                         clock,
    input  logic                         reset_N,
    input  logic                         patWrite,
    input  logic [dnaPkg::PatAddrW-1:0] patAddr,
    input  dnaPkg::tokenT                patData,
    input  logic                         seqWrite,
    input  logic [dnaPkg::SeqAddrW-1:0] seqAddr,
    input  dnaPkg::letterT               seqData,
    input  logic                         start,
    output logic                         busy,
    output logic                         done,
    output logic                         foundIt,
    output logic                         error,
    output logic [dnaPkg::SeqAddrW-1:0] matchLength
);

    logic [dnaPkg::PatAddrW-1:0] patReadAddr;
    logic [dnaPkg::SeqAddrW-1:0] seqReadAddr;
    logic [dnaPkg::RunW-1:0]     runCount;
    dnaPkg::tokenT                patToken;
    dnaPkg::letterT               seqLetter;
    dnaPkg::letterMaskT           memberMask;
    logic                         runFull;
    logic                         patOverflow;
    logic                         badMember;
    logic                         patClear;
    logic                         patStep;
    logic                         seqClear;
    logic                         seqStep;
    logic                         runClear;
    logic                         runStep;
    logic                         collectClear;
    logic                         collectTake;

    symbolStore #(
        .payloadT(dnaPkg::tokenT),
        .depth(dnaPkg::PatDepth)
    ) patStore (
        .clock(clock),
        .write(patWrite),
        .writeAddr(patAddr),
        .writeData(patData),
        .readAddr(patReadAddr),
        .readData(patToken)
    );

    symbolStore #(
        .payloadT(dnaPkg::letterT),
        .depth(dnaPkg::SeqDepth)
    ) seqStore (
        .clock(clock),
        .write(seqWrite),
        .writeAddr(seqAddr),
        .writeData(seqData),
        .readAddr(seqReadAddr),
        .readData(seqLetter)
    );

    fetchStage fetch (
        .clock(clock),
        .reset_N(reset_N),
        .patClear(patClear),
        .patStep(patStep),
        .seqClear(seqClear),
        .seqStep(seqStep),
        .runClear(runClear),
        .runStep(runStep),
        .patAddr(patReadAddr),
        .seqAddr(seqReadAddr),
        .runCount(runCount),
        .runFull(runFull),
        .patOverflow(patOverflow)
    );

    setCollector collector (
        .clock(clock),
        .reset_N(reset_N),
        .collectClear(collectClear),
        .collectTake(collectTake),
        .patToken(patToken),
        .memberMask(memberMask),
        .badMember(badMember)
    );

    matchController control (
        .clock(clock),
        .reset_N(reset_N),
        .start(start),
        .patWrite(patWrite),
        .seqWrite(seqWrite),
        .patToken(patToken),
        .seqLetter(seqLetter),
        .seqAddr(seqReadAddr),
        .runCount(runCount),
        .runFull(runFull),
        .patOverflow(patOverflow),
        .memberMask(memberMask),
        .badMember(badMember),
        .patClear(patClear),
        .patStep(patStep),
        .seqClear(seqClear),
        .seqStep(seqStep),
        .runClear(runClear),
        .runStep(runStep),
        .collectClear(collectClear),
        .collectTake(collectTake),
        .busy(busy),
        .done(done),
        .foundIt(foundIt),
        .error(error),
        .matchLength(matchLength)
    );

endmodule

/* verilog/dnaPkg.sv */
package dnaPkg;

    // Sequence letters
    typedef logic [2:0] letterT;

    localparam letterT LetterA = 3'd0;
    localparam letterT LetterC = 3'd1;
    localparam letterT LetterT = 3'd2;
    localparam letterT LetterG = 3'd3;
    localparam letterT LetterEnd = 3'd4;    // End of sequence
    localparam letterT LetterOther = 3'd7;  // Matches nothing

    // Pattern tokens, codes 0 to 3 are literal letters
    typedef logic [3:0] tokenT;

    localparam tokenT TokenSet2 = 4'd4;       // Followed by two members
    localparam tokenT TokenSet3 = 4'd5;       // Followed by three members
    localparam tokenT TokenOneOrMore = 4'd6;
    localparam tokenT TokenZeroOrMore = 4'd7;
    localparam tokenT TokenEnd = 4'd8;

    // Store depths and counter widths
    localparam int PatDepth = 32;
    localparam int SeqDepth = 64;
    localparam int PatAddrW = $clog2(PatDepth);
    localparam int SeqAddrW = $clog2(SeqDepth);
    localparam int MaxRun = 15;
    localparam int RunW = 4;

    typedef logic [PatAddrW-1:0] patAddrT;
    typedef logic [SeqAddrW-1:0] seqAddrT;
    typedef logic [RunW-1:0] runT;

    // One bit per letter A, C, T, G
    typedef logic [3:0] letterMaskT;

    function automatic logic isLiteral(tokenT token);
        return token < TokenSet2;
    endfunction

endpackage

/* verilog/fetchStage.sv */
`timescale 1ns/100ps

module fetchStage (
    input  logic                         clock,
    input  logic                         reset_N,
    input  logic                         patClear,
    input  logic                         patStep,
    input  logic                         seqClear,
    input  logic                         seqStep,
    input  logic                         runClear,
    input  logic                         runStep,
    output logic [dnaPkg::PatAddrW-1:0] patAddr,
    output logic [dnaPkg::SeqAddrW-1:0] seqAddr,
    output logic [dnaPkg::RunW-1:0]     runCount,
    output logic                         runFull,
    output logic                         patOverflow
);

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            patAddr <= '0;
            patOverflow <= 1'b0;
        end else if (patClear) begin
            patAddr <= '0;
            patOverflow <= 1'b0;
        end else if (patStep) begin
            patAddr <= patAddr + 1'b1;
            if (patAddr == dnaPkg::patAddrT'(dnaPkg::PatDepth - 1)) begin
                patOverflow <= 1'b1;  // Wrapped without an end token
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            seqAddr <= '0;
        end else if (seqClear) begin
            seqAddr <= '0;
        end else if (seqStep) begin
            seqAddr <= seqAddr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            runCount <= '0;
        end else if (runClear) begin
            runCount <= '0;
        end else if (runStep) begin
            runCount <= runCount + 1'b1;
        end
    end

    assign runFull = runCount == dnaPkg::runT'(dnaPkg::MaxRun);

    // A loaded sequence must reach LetterEnd before the last entry
    assert property (@(posedge clock) disable iff (!reset_N)
        seqStep && !seqClear |-> seqAddr != dnaPkg::seqAddrT'(dnaPkg::SeqDepth - 1))
        else $error("sequence address stepped past the last entry");

    assert property (@(posedge clock) disable iff (!reset_N) !(runStep && runFull))
        else $error("run counter stepped while full");

endmodule

/* verilog/matchController.sv */
`timescale 1ns/100ps

module matchController (
    input  logic                         clock,
    input  logic                         reset_N,
    input  logic                         start,
    input  logic                         patWrite,
    input  logic                         seqWrite,
    input  dnaPkg::tokenT                patToken,
    input  dnaPkg::letterT               seqLetter,
    input  logic [dnaPkg::SeqAddrW-1:0] seqAddr,
    input  logic [dnaPkg::RunW-1:0]     runCount,
    input  logic                         runFull,
    input  logic                         patOverflow,
    input  dnaPkg::letterMaskT           memberMask,
    input  logic                         badMember,
    output logic                         patClear,
    output logic                         patStep,
    output logic                         seqClear,
    output logic                         seqStep,
    output logic                         runClear,
    output logic                         runStep,
    output logic                         collectClear,
    output logic                         collectTake,
    output logic                         busy,
    output logic                         done,
    output logic                         foundIt,
    output logic                         error,
    output logic [dnaPkg::SeqAddrW-1:0] matchLength
);

    typedef enum logic [3:0] {
        Idle,
        ReadToken,
        DecodeToken,
        MemberWait,
        CollectMember,
        CompareSet,
        RepeatWait,
        RepeatLoop,
        SeqWait,
        Found,
        NotFound,
        Failed
    } stateT;

    stateT      state;
    stateT      nextState;
    logic [1:0] membersLeft;
    logic       repOne;       // One-or-more needs a nonzero run
    logic       letterHit;
    logic       setHit;

    assign letterHit = seqLetter == dnaPkg::letterT'(patToken);
    assign setHit = seqLetter <= dnaPkg::LetterG && memberMask[seqLetter[1:0]];

    always_comb begin
        nextState = state;
        patClear = 1'b0;
        patStep = 1'b0;
        seqClear = 1'b0;
        seqStep = 1'b0;
        runClear = 1'b0;
        runStep = 1'b0;
        collectClear = 1'b0;
        collectTake = 1'b0;
        unique case (state)
            Idle: begin
                if (start) begin
                    patClear = 1'b1;
                    seqClear = 1'b1;
                    runClear = 1'b1;
                    collectClear = 1'b1;
                    nextState = ReadToken;
                end
            end
            ReadToken: nextState = DecodeToken;  // Wait for the store read
            DecodeToken: begin
                if (patOverflow) begin
                    nextState = Failed;
                end else if (dnaPkg::isLiteral(patToken)) begin
                    if (letterHit) begin
                        patStep = 1'b1;
                        seqStep = 1'b1;
                        nextState = ReadToken;
                    end else begin
                        nextState = NotFound;
                    end
                end else begin
                    case (patToken)
                        dnaPkg::TokenSet2, dnaPkg::TokenSet3: begin
                            collectClear = 1'b1;
                            patStep = 1'b1;
                            nextState = MemberWait;
                        end
                        dnaPkg::TokenOneOrMore, dnaPkg::TokenZeroOrMore: begin
                            runClear = 1'b1;
                            patStep = 1'b1;
                            nextState = RepeatWait;
                        end
                        dnaPkg::TokenEnd: nextState = Found;
                        default: nextState = Failed;  // Invalid code
                    endcase
                end
            end
            MemberWait: nextState = CollectMember;
            CollectMember: begin
                if (patOverflow) begin
                    nextState = Failed;
                end else begin
                    collectTake = 1'b1;
                    patStep = 1'b1;
                    nextState = (membersLeft == 2'd1) ? CompareSet : MemberWait;
                end
            end
            CompareSet: begin
                if (badMember) begin
                    nextState = Failed;
                end else if (setHit) begin
                    seqStep = 1'b1;
                    nextState = ReadToken;
                end else begin
                    nextState = NotFound;
                end
            end
            RepeatWait: nextState = RepeatLoop;
            RepeatLoop: begin
                // Token stays on the repeated literal for the whole run
                if (patOverflow || !dnaPkg::isLiteral(patToken)) begin
                    nextState = Failed;
                end else if (letterHit && !runFull) begin
                    seqStep = 1'b1;
                    runStep = 1'b1;
                    nextState = SeqWait;
                end else if (repOne && runCount == '0) begin
                    nextState = NotFound;
                end else begin
                    patStep = 1'b1;
                    nextState = ReadToken;
                end
            end
            SeqWait: nextState = RepeatLoop;
            Found, NotFound, Failed: nextState = Idle;
            default: nextState = Idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            membersLeft <= '0;
            repOne <= 1'b0;
        end else if (state == DecodeToken) begin
            if (patToken == dnaPkg::TokenSet2 || patToken == dnaPkg::TokenSet3) begin
                membersLeft <= (patToken == dnaPkg::TokenSet3) ? 2'd3 : 2'd2;
            end
            if (patToken == dnaPkg::TokenOneOrMore || patToken == dnaPkg::TokenZeroOrMore) begin
                repOne <= patToken == dnaPkg::TokenOneOrMore;
            end
        end else if (state == CollectMember && !patOverflow) begin
            membersLeft <= membersLeft - 1'b1;
        end
    end

    // Result flags held until the next accepted start
    always_ff @(posedge clock) begin
        if (!reset_N) begin
            busy <= 1'b0;
            done <= 1'b0;
            foundIt <= 1'b0;
            error <= 1'b0;
            matchLength <= '0;
        end else if (state == Idle && start) begin
            busy <= 1'b1;
            done <= 1'b0;
            foundIt <= 1'b0;
            error <= 1'b0;
            matchLength <= '0;
        end else if (state == Found || state == NotFound || state == Failed) begin
            busy <= 1'b0;
            done <= 1'b1;
            foundIt <= state == Found;
            error <= state == Failed;
            matchLength <= (state == Found) ? seqAddr : '0;  // Letters consumed
        end
    end

    assert property (@(posedge clock) disable iff (!reset_N) !(foundIt && error))
        else $error("foundIt and error both high");

    // Stores must stay still while a search reads them
    assert property (@(posedge clock) disable iff (!reset_N) busy |-> !(patWrite || seqWrite))
        else $error("store written during a search");

endmodule

/* verilog/setCollector.sv */
`timescale 1ns/100ps

module setCollector (
    input  logic               clock,
    input  logic               reset_N,
    input  logic               collectClear,
    input  logic               collectTake,
    input  dnaPkg::tokenT      patToken,
    output dnaPkg::letterMaskT memberMask,
    output logic               badMember
);

    logic               literal;
    logic               duplicate;
    dnaPkg::letterMaskT tokenBit;

    assign literal = dnaPkg::isLiteral(patToken);

    // One-hot letter bit of the member, empty for a non-letter
    assign tokenBit = literal ? dnaPkg::letterMaskT'(1) << patToken[1:0] : '0;
    assign duplicate = (memberMask & tokenBit) != '0;

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            memberMask <= '0;
        end else if (collectClear) begin
            memberMask <= '0;
        end else if (collectTake) begin
            memberMask <= memberMask | tokenBit;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            badMember <= 1'b0;
        end else if (collectClear) begin
            badMember <= 1'b0;
        end else if (collectTake && (!literal || duplicate)) begin
            badMember <= 1'b1;  // Sticky until the next set
        end
    end

endmodule

/* verilog/symbolStore.sv */
`timescale 1ns/100ps

module symbolStore #(
    parameter type payloadT = logic [7:0],
    parameter int depth = 32
) (
    input  logic                     clock,
    input  logic                     write,
    input  logic [$clog2(depth)-1:0] writeAddr,
    input  payloadT                  writeData,
    input  logic [$clog2(depth)-1:0] readAddr,
    output payloadT                  readData
);

    payloadT mem [depth];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clock) begin
        readData <= mem[readAddr];
    end

endmodule
